//--- design/dma_pkg.sv
package dma_pkg;

  //////////////////////////////
  // Widths and counts
  localparam int DATA_W        = 32;
  localparam int TABLE_ENTRIES = 4;
  localparam int ENTRY_W       = 2;
  localparam int LEN_W         = 4;
  localparam int N_MASTERS     = 2;

  // Master slots behind the memory arbiter
  localparam int M_INIT = 0;
  localparam int M_TGT  = 1;

  //////////////////////////////
  // Register map, byte offset inside an entry's 16-byte block
  localparam logic [3:0] REG_LOCAL  = 4'h0;
  localparam logic [3:0] REG_REMOTE = 4'h4;
  localparam logic [3:0] REG_LEN    = 4'h8;
  localparam logic [3:0] REG_CTRL   = 4'hC;

  // CTRL bits
  localparam int CTRL_START = 0;
  localparam int CTRL_DONE  = 1;

  // Packet kinds
  localparam logic [1:0] KIND_REQ = 2'd1;
  localparam logic [1:0] KIND_ACK = 2'd2;

  // AHB transfer types
  localparam logic [1:0] HT_IDLE   = 2'b00;
  localparam logic [1:0] HT_NONSEQ = 2'b10;

  //////////////////////////////
  // Types
  typedef logic [TABLE_ENTRIES-1:0] entry_mask_t;

  typedef struct packed {
    logic [DATA_W-1:0] local_addr;
    logic [DATA_W-1:0] remote_addr;
    logic [LEN_W-1:0]  len;
  } dma_req_t;

  typedef struct packed {
    logic              sel;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              write;
    logic [1:0]        trans;
    logic              mastlock;
  } ahb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              ready;
    logic              resp;
  } ahb_rsp_t;

  typedef struct packed {
    logic [DATA_W-1:0] payload;
    logic              last;
  } noc_flit_t;

  // Payload of the first flit of every packet
  typedef struct packed {
    logic [1:0]                        kind;
    logic [ENTRY_W-1:0]                index;
    logic [LEN_W-1:0]                  len;
    logic [DATA_W-2-ENTRY_W-LEN_W-1:0] rsvd;
  } noc_header_t;

endpackage

//--- design/dma_cfg_slave.sv
`timescale 1ns/1ps

module dma_cfg_slave
  import dma_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  ahb_req_t           cfg_req,
  output ahb_rsp_t           cfg_rsp,
  output logic [ENTRY_W-1:0] tbl_index,
  output dma_req_t           tbl_entry,
  output logic [3:0]         tbl_field,
  output logic               tbl_write,
  output logic               tbl_start,
  output logic               tbl_clear,
  input  dma_req_t           rd_entry,
  input  entry_mask_t        valid,
  input  entry_mask_t        done
);

  logic               dph_active;
  logic               dph_write;
  logic [ENTRY_W-1:0] dph_index;
  logic [3:0]         dph_reg;
  logic [DATA_W-1:0]  rdata;

  //////////////////////////////
  // Address phase
  always_ff @(posedge clk) begin
    if (rst) begin
      dph_active <= 1'b0;
      dph_write  <= 1'b0;
    end else begin
      dph_active <= cfg_req.sel && (cfg_req.trans == HT_NONSEQ);
      dph_write  <= cfg_req.write;
    end
  end

  // Entry in addr[5:4], register in addr[3:0]
  always_ff @(posedge clk) begin
    dph_index <= cfg_req.addr[4 +: ENTRY_W];
    dph_reg   <= cfg_req.addr[3:0];
  end

  //////////////////////////////
  // Data phase, writes
  assign tbl_index = dph_index;
  assign tbl_field = dph_reg;

  // Every field carries the bus word, the table picks by tbl_field
  assign tbl_entry = '{
    local_addr:  cfg_req.wdata,
    remote_addr: cfg_req.wdata,
    len:         cfg_req.wdata[LEN_W-1:0]
  };

  always_comb begin
    tbl_write = 1'b0;
    tbl_start = 1'b0;
    tbl_clear = 1'b0;
    if (dph_active && dph_write) begin
      case (dph_reg)
        REG_LOCAL, REG_REMOTE, REG_LEN: tbl_write = 1'b1;
        REG_CTRL: begin
          tbl_start = cfg_req.wdata[CTRL_START];
          tbl_clear = cfg_req.wdata[CTRL_DONE];
        end
        default: ;
      endcase
    end
  end

  // Data phase, reads see the table as it stands this cycle
  always_comb begin
    rdata = '0;
    case (dph_reg)
      REG_LOCAL:  rdata = rd_entry.local_addr;
      REG_REMOTE: rdata = rd_entry.remote_addr;
      REG_LEN:    rdata = DATA_W'(rd_entry.len);
      REG_CTRL: begin
        rdata[CTRL_START] = valid[dph_index];
        rdata[CTRL_DONE]  = done[dph_index];
      end
      default: ;
    endcase
  end

  // No wait states, always OKAY
  assign cfg_rsp = '{rdata: rdata, ready: 1'b1, resp: 1'b0};

endmodule

//--- design/dma_transfer_table.sv
`timescale 1ns/1ps

module dma_transfer_table
  import dma_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [ENTRY_W-1:0] tbl_index,
  input  dma_req_t           tbl_entry,
  input  logic [3:0]         tbl_field,
  input  logic               tbl_write,
  input  logic               tbl_start,
  input  logic               tbl_clear,
  output dma_req_t           rd_entry,
  input  logic [ENTRY_W-1:0] init_index,
  output dma_req_t           init_entry,
  input  logic               take,
  input  logic               done_pulse,
  input  logic [ENTRY_W-1:0] done_index,
  output entry_mask_t        valid,
  output entry_mask_t        done,
  output entry_mask_t        irq
);

  dma_req_t    entries [TABLE_ENTRIES];
  entry_mask_t valid_q;
  entry_mask_t done_q;
  entry_mask_t irq_q;

  // Field writes from the config slave
  always_ff @(posedge clk) begin
    if (tbl_write) begin
      case (tbl_field)
        REG_LOCAL:  entries[tbl_index].local_addr  <= tbl_entry.local_addr;
        REG_REMOTE: entries[tbl_index].remote_addr <= tbl_entry.remote_addr;
        REG_LEN:    entries[tbl_index].len         <= tbl_entry.len;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Status flags
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      done_q  <= '0;
      irq_q   <= '0;
    end else begin
      if (take) valid_q[init_index] <= 1'b0;
      // A fresh start overrides take and clears an old done
      if (tbl_start) valid_q[tbl_index] <= 1'b1;
      if (done_pulse) done_q[done_index] <= 1'b1;
      if (tbl_clear) done_q[tbl_index] <= 1'b0;
      if (tbl_start) done_q[tbl_index] <= 1'b0;
      irq_q <= done_q;
    end
  end

  assign rd_entry   = entries[tbl_index];
  assign init_entry = entries[init_index];
  assign valid      = valid_q;
  assign done       = done_q;
  assign irq        = irq_q;

  // The initiator only takes an entry that is still pending
  a_take_valid: assert property (
    @(posedge clk) disable iff (rst) take |-> valid_q[init_index]
  );

endmodule

//--- design/dma_initiator.sv
`timescale 1ns/1ps

module dma_initiator
  import dma_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  entry_mask_t        valid,
  output logic [ENTRY_W-1:0] init_index,
  input  dma_req_t           init_entry,
  output logic               take,
  output logic               done_pulse,
  output logic [ENTRY_W-1:0] done_index,
  output noc_flit_t          noc_out,
  output logic               noc_out_valid,
  input  logic               noc_out_ready,
  input  noc_flit_t          noc_in,
  input  logic               noc_in_valid,
  output logic               noc_in_ready,
  output ahb_req_t           bus_req,
  input  ahb_rsp_t           bus_rsp
);

  typedef enum logic [2:0] {
    S_IDLE, S_HDR, S_ADDR, S_RD_ADDR, S_RD_DATA, S_SEND, S_WAIT_ACK
  } state_e;

  state_e             state;
  logic [ENTRY_W-1:0] idx_q;
  logic [LEN_W-1:0]   len_q;
  logic [LEN_W-1:0]   count_q;
  logic [DATA_W-1:0]  addr_q;
  logic [DATA_W-1:0]  remote_q;
  logic [DATA_W-1:0]  data_q;
  logic               last_word;
  noc_header_t        hdr;
  noc_header_t        ack;

  // Priority pick, lowest index wins
  always_comb begin
    init_index = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid[i]) init_index = ENTRY_W'(i);
    end
  end

  assign take      = (state == S_IDLE) && (|valid);
  assign last_word = (count_q == len_q);

  // Acknowledge matching by entry index
  assign ack          = noc_header_t'(noc_in.payload);
  assign noc_in_ready = (state == S_WAIT_ACK);
  assign done_pulse   = noc_in_ready && noc_in_valid &&
                        (ack.kind == KIND_ACK) && (ack.index == idx_q);
  assign done_index   = idx_q;

  //////////////////////////////
  // FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:     if (take) state <= S_HDR;
        S_HDR:      if (noc_out_ready) state <= S_ADDR;
        S_ADDR:     if (noc_out_ready) state <= S_RD_ADDR;
        S_RD_ADDR:  if (bus_rsp.ready) state <= S_RD_DATA;
        S_RD_DATA:  if (bus_rsp.ready) state <= S_SEND;
        S_SEND: begin
          if (noc_out_ready) state <= last_word ? S_WAIT_ACK : S_RD_ADDR;
        end
        S_WAIT_ACK: if (done_pulse) state <= S_IDLE;
        default:    state <= S_IDLE;
      endcase
    end
  end

  // Entry copy, word counter and local address counter
  always_ff @(posedge clk) begin
    if (take) begin
      idx_q    <= init_index;
      len_q    <= init_entry.len;
      addr_q   <= init_entry.local_addr;
      remote_q <= init_entry.remote_addr;
      count_q  <= '0;
    end
    if ((state == S_RD_DATA) && bus_rsp.ready) data_q <= bus_rsp.rdata;
    if ((state == S_SEND) && noc_out_ready) begin
      count_q <= count_q + 1'b1;
      addr_q  <= addr_q + DATA_W'(4);
    end
  end

  // Request packet flits
  always_comb begin
    hdr           = '0;
    hdr.kind      = KIND_REQ;
    hdr.index     = idx_q;
    hdr.len       = len_q;
    noc_out.payload = hdr;
    noc_out.last    = 1'b0;
    noc_out_valid   = 1'b0;
    case (state)
      S_HDR: noc_out_valid = 1'b1;
      S_ADDR: begin
        noc_out_valid   = 1'b1;
        noc_out.payload = remote_q;
      end
      S_SEND: begin
        noc_out_valid   = 1'b1;
        noc_out.payload = data_q;
        noc_out.last    = last_word;
      end
      default: ;
    endcase
  end

  // Single reads, lock held over both phases
  always_comb begin
    bus_req          = '0;
    bus_req.addr     = addr_q;
    bus_req.trans    = HT_IDLE;
    bus_req.sel      = (state == S_RD_ADDR);
    bus_req.mastlock = (state == S_RD_ADDR) || (state == S_RD_DATA);
    if (state == S_RD_ADDR) bus_req.trans = HT_NONSEQ;
  end

  a_flit_hold: assert property (
    @(posedge clk) disable iff (rst)
    noc_out_valid && !noc_out_ready |=> noc_out_valid && $stable(noc_out)
  );

endmodule

//--- design/dma_target.sv
`timescale 1ns/1ps

module dma_target
  import dma_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  noc_flit_t noc_in,
  input  logic      noc_in_valid,
  output logic      noc_in_ready,
  output noc_flit_t noc_out,
  output logic      noc_out_valid,
  input  logic      noc_out_ready,
  output ahb_req_t  bus_req,
  input  ahb_rsp_t  bus_rsp
);

  typedef enum logic [2:0] {
    T_HDR, T_ADDR, T_DATA, T_WR_ADDR, T_WR_DATA, T_ACK
  } state_e;

  state_e             state;
  logic [ENTRY_W-1:0] idx_q;
  logic [LEN_W-1:0]   len_q;
  logic [DATA_W-1:0]  addr_q;
  logic [DATA_W-1:0]  data_q;
  logic               last_q;
  logic               accept;
  noc_header_t        hdr_in;
  noc_header_t        ack;

  assign hdr_in       = noc_header_t'(noc_in.payload);
  assign noc_in_ready = (state == T_HDR) || (state == T_ADDR) || (state == T_DATA);
  assign accept       = noc_in_valid && noc_in_ready;

  //////////////////////////////
  // FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= T_HDR;
    end else begin
      case (state)
        // Anything other than a request header is dropped
        T_HDR:     if (accept && (hdr_in.kind == KIND_REQ)) state <= T_ADDR;
        T_ADDR:    if (accept) state <= T_DATA;
        T_DATA:    if (accept) state <= T_WR_ADDR;
        T_WR_ADDR: if (bus_rsp.ready) state <= T_WR_DATA;
        T_WR_DATA: if (bus_rsp.ready) state <= last_q ? T_ACK : T_DATA;
        T_ACK:     if (noc_out_ready) state <= T_HDR;
        default:   state <= T_HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == T_HDR) && accept) begin
      idx_q <= hdr_in.index;
      len_q <= hdr_in.len;
    end
    if ((state == T_ADDR) && accept) addr_q <= noc_in.payload;
    if ((state == T_DATA) && accept) begin
      data_q <= noc_in.payload;
      last_q <= noc_in.last;
    end
    // Next word goes one address up
    if ((state == T_WR_DATA) && bus_rsp.ready) addr_q <= addr_q + DATA_W'(4);
  end

  // One-flit acknowledge
  always_comb begin
    ack             = '0;
    ack.kind        = KIND_ACK;
    ack.index       = idx_q;
    ack.len         = len_q;
    noc_out.payload = ack;
    noc_out.last    = 1'b1;
    noc_out_valid   = (state == T_ACK);
  end

  always_comb begin
    bus_req          = '0;
    bus_req.addr     = addr_q;
    bus_req.wdata    = data_q;
    bus_req.trans    = HT_IDLE;
    bus_req.sel      = (state == T_WR_ADDR);
    bus_req.write    = (state == T_WR_ADDR);
    bus_req.mastlock = (state == T_WR_ADDR) || (state == T_WR_DATA);
    if (state == T_WR_ADDR) bus_req.trans = HT_NONSEQ;
  end

endmodule

//--- design/dma_bus_arbiter.sv
`timescale 1ns/1ps

module dma_bus_arbiter
  import dma_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  ahb_req_t init_req,
  output ahb_rsp_t init_rsp,
  input  ahb_req_t tgt_req,
  output ahb_rsp_t tgt_rsp,
  output ahb_req_t mem_req,
  input  ahb_rsp_t mem_rsp
);

  // One-hot grant, one bit per master slot
  logic [N_MASTERS-1:0] grant;
  logic [N_MASTERS-1:0] grant_nxt;
  logic [N_MASTERS-1:0] lock;
  logic                 owner_lock;

  assign lock[M_INIT] = init_req.mastlock;
  assign lock[M_TGT]  = tgt_req.mastlock;
  assign owner_lock   = |(grant & lock);

  // Owner keeps the bus while locked, else target first
  always_comb begin
    grant_nxt = '0;
    if (owner_lock) begin
      grant_nxt = grant;
    end else if (lock[M_INIT] && !lock[M_TGT]) begin
      grant_nxt[M_INIT] = 1'b1;
    end else begin
      grant_nxt[M_TGT] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= N_MASTERS'(1) << M_TGT;
    end else begin
      grant <= grant_nxt;
    end
  end

  //////////////////////////////
  // Muxes
  always_comb begin
    mem_req        = grant[M_TGT] ? tgt_req : init_req;
    init_rsp       = mem_rsp;
    tgt_rsp        = mem_rsp;
    init_rsp.ready = grant[M_INIT] && mem_rsp.ready;
    tgt_rsp.ready  = grant[M_TGT] && mem_rsp.ready;
  end

  a_grant_held: assert property (
    @(posedge clk) disable iff (rst) owner_lock |=> grant == $past(grant)
  );

endmodule

//--- design/dma_top.sv
`timescale 1ns/1ps

module dma_top
  import dma_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  ahb_req_t    cfg_req,
  output ahb_rsp_t    cfg_rsp,
  output ahb_req_t    mem_req,
  input  ahb_rsp_t    mem_rsp,
  output noc_flit_t   noc_out_req_flit,
  output logic        noc_out_req_valid,
  input  logic        noc_out_req_ready,
  output noc_flit_t   noc_out_res_flit,
  output logic        noc_out_res_valid,
  input  logic        noc_out_res_ready,
  input  noc_flit_t   noc_in_req_flit,
  input  logic        noc_in_req_valid,
  output logic        noc_in_req_ready,
  input  noc_flit_t   noc_in_res_flit,
  input  logic        noc_in_res_valid,
  output logic        noc_in_res_ready,
  output entry_mask_t irq
);

  // Table write port
  logic [ENTRY_W-1:0] tbl_index;
  dma_req_t           tbl_entry;
  logic [3:0]         tbl_field;
  logic               tbl_write;
  logic               tbl_start;
  logic               tbl_clear;
  dma_req_t           rd_entry;
  entry_mask_t        valid;
  entry_mask_t        done;

  // Initiator side of the table
  logic [ENTRY_W-1:0] init_index;
  dma_req_t           init_entry;
  logic               take;
  logic               done_pulse;
  logic [ENTRY_W-1:0] done_index;

  // Memory masters ahead of the arbiter
  ahb_req_t           init_req;
  ahb_rsp_t           init_rsp;
  ahb_req_t           tgt_req;
  ahb_rsp_t           tgt_rsp;

  dma_cfg_slave i_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_req   (cfg_req),
    .cfg_rsp   (cfg_rsp),
    .tbl_index (tbl_index),
    .tbl_entry (tbl_entry),
    .tbl_field (tbl_field),
    .tbl_write (tbl_write),
    .tbl_start (tbl_start),
    .tbl_clear (tbl_clear),
    .rd_entry  (rd_entry),
    .valid     (valid),
    .done      (done)
  );

  dma_transfer_table i_table (
    .clk        (clk),
    .rst        (rst),
    .tbl_index  (tbl_index),
    .tbl_entry  (tbl_entry),
    .tbl_field  (tbl_field),
    .tbl_write  (tbl_write),
    .tbl_start  (tbl_start),
    .tbl_clear  (tbl_clear),
    .rd_entry   (rd_entry),
    .init_index (init_index),
    .init_entry (init_entry),
    .take       (take),
    .done_pulse (done_pulse),
    .done_index (done_index),
    .valid      (valid),
    .done       (done),
    .irq        (irq)
  );

  //////////////////////////////
  // Requests go out, acknowledges come back
  dma_initiator i_init (
    .clk           (clk),
    .rst           (rst),
    .valid         (valid),
    .init_index    (init_index),
    .init_entry    (init_entry),
    .take          (take),
    .done_pulse    (done_pulse),
    .done_index    (done_index),
    .noc_out       (noc_out_req_flit),
    .noc_out_valid (noc_out_req_valid),
    .noc_out_ready (noc_out_req_ready),
    .noc_in        (noc_in_res_flit),
    .noc_in_valid  (noc_in_res_valid),
    .noc_in_ready  (noc_in_res_ready),
    .bus_req       (init_req),
    .bus_rsp       (init_rsp)
  );

  dma_target i_tgt (
    .clk           (clk),
    .rst           (rst),
    .noc_in        (noc_in_req_flit),
    .noc_in_valid  (noc_in_req_valid),
    .noc_in_ready  (noc_in_req_ready),
    .noc_out       (noc_out_res_flit),
    .noc_out_valid (noc_out_res_valid),
    .noc_out_ready (noc_out_res_ready),
    .bus_req       (tgt_req),
    .bus_rsp       (tgt_rsp)
  );

  dma_bus_arbiter i_arb (
    .clk      (clk),
    .rst      (rst),
    .init_req (init_req),
    .init_rsp (init_rsp),
    .tgt_req  (tgt_req),
    .tgt_rsp  (tgt_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

endmodule

//--- testbench/dma_tb_mem.sv
`timescale 1ns/1ps

module dma_tb_mem
  import dma_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     wait_en,
  input  ahb_req_t mem_req,
  output ahb_rsp_t mem_rsp
);

  localparam int          MEM_WORDS = 256;
  localparam logic [31:0] SEED      = 32'h910f3e5a;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic              dph_pending;
  logic              dph_write;
  logic [7:0]        dph_word;
  logic [1:0]        wait_cnt;
  logic [31:0]       lfsr_q;
  logic [31:0]       lfsr_a;
  logic [31:0]       lfsr_b;
  logic              ready;
  logic              addr_phase;

  // Fibonacci LFSR, taps 32 22 2 1, new bit shifts in at bit 0
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  assign ready      = !dph_pending || (wait_cnt == 2'd0);
  assign addr_phase = mem_req.sel && (mem_req.trans == HT_NONSEQ);

  // Two steps give the two bits of one wait count
  always_comb begin
    lfsr_a = lfsr_step(lfsr_q);
    lfsr_b = lfsr_step(lfsr_a);
  end

  //////////////////////////////
  // Address and data phase
  always @(posedge clk) begin
    if (rst) begin
      dph_pending <= 1'b0;
      dph_write   <= 1'b0;
      wait_cnt    <= 2'd0;
      lfsr_q      <= SEED;
    end else begin
      if (dph_pending && !ready) wait_cnt <= wait_cnt - 2'd1;
      if (ready) begin
        if (dph_pending && dph_write) mem[dph_word] <= mem_req.wdata;
        dph_pending <= addr_phase;
        if (addr_phase) begin
          dph_write <= mem_req.write;
          dph_word  <= mem_req.addr[9:2];
          if (wait_en) begin
            wait_cnt <= {lfsr_a[0], lfsr_b[0]};
            lfsr_q   <= lfsr_b;
          end else begin
            wait_cnt <= 2'd0;
          end
        end
      end
    end
  end

  // Read data is valid in the cycle the data phase ends
  assign mem_rsp.rdata = mem[dph_word];
  assign mem_rsp.ready = ready;
  assign mem_rsp.resp  = 1'b0;

endmodule

//--- testbench/dma_tb.sv
`timescale 1ns/1ps

module dma_tb
  import dma_pkg::*;
();

  localparam int          CLK_HALF  = 50;
  localparam int          MEM_WORDS = 256;
  localparam int          TIMEOUT   = 5000;
  localparam logic [31:0] SEED      = 32'h910f3e5a;

  logic        clk;
  logic        rst;
  ahb_req_t    cfg_req;
  ahb_rsp_t    cfg_rsp;
  ahb_req_t    mem_req;
  ahb_rsp_t    mem_rsp;
  noc_flit_t   req_flit;
  logic        req_out_valid;
  logic        req_out_ready;
  logic        req_in_valid;
  logic        req_in_ready;
  noc_flit_t   res_flit;
  logic        res_out_valid;
  logic        res_out_ready;
  logic        res_in_valid;
  logic        res_in_ready;
  entry_mask_t irq;

  logic        req_stall;
  logic        res_stall;
  logic        stall_en;
  logic        wait_en;
  logic [31:0] rnd_q;
  logic [31:0] stall_bits;

  // Transfer set in word indices
  logic [DATA_W-1:0] init_img [MEM_WORDS];
  int                src_word [TABLE_ENTRIES];
  int                dst_word [TABLE_ENTRIES];
  int                n_words  [TABLE_ENTRIES];
  logic              xfer_on  [TABLE_ENTRIES];

  // Request monitor state
  int                 pkt_pos;
  int                 hdr_count = 0;
  logic [ENTRY_W-1:0] pkt_idx;
  noc_header_t        hdr_seen;
  noc_header_t        hdr_exp;
  noc_flit_t          flit_exp;
  noc_header_t        ack_seen;

  always #(CLK_HALF) clk = ~clk;

  // NoC loopback with stall gating
  assign req_in_valid  = req_out_valid && !req_stall;
  assign req_out_ready = req_in_ready && !req_stall;
  assign res_in_valid  = res_out_valid && !res_stall;
  assign res_out_ready = res_in_ready && !res_stall;

  dma_top i_dut (
    .clk               (clk),
    .rst               (rst),
    .cfg_req           (cfg_req),
    .cfg_rsp           (cfg_rsp),
    .mem_req           (mem_req),
    .mem_rsp           (mem_rsp),
    .noc_out_req_flit  (req_flit),
    .noc_out_req_valid (req_out_valid),
    .noc_out_req_ready (req_out_ready),
    .noc_out_res_flit  (res_flit),
    .noc_out_res_valid (res_out_valid),
    .noc_out_res_ready (res_out_ready),
    .noc_in_req_flit   (req_flit),
    .noc_in_req_valid  (req_in_valid),
    .noc_in_req_ready  (req_in_ready),
    .noc_in_res_flit   (res_flit),
    .noc_in_res_valid  (res_in_valid),
    .noc_in_res_ready  (res_in_ready),
    .irq               (irq)
  );

  dma_tb_mem i_mem (
    .clk     (clk),
    .rst     (rst),
    .wait_en (wait_en),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  //////////////////////////////
  // Checks
  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flit(input string name, input noc_flit_t got, input noc_flit_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got payload %h last %h, expected payload %h last %h",
               name, got.payload, got.last, exp.payload, exp.last);
      abort_run();
    end
  endtask

  task automatic check_irq(input entry_mask_t got, input entry_mask_t exp);
    if (got !== exp) begin
      $display("ERROR irq: got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  // Config slave answers OKAY with no wait states
  task automatic check_cfg_rsp();
    check_word("cfg_rsp.ready", DATA_W'(cfg_rsp.ready), DATA_W'(1));
    check_word("cfg_rsp.resp", DATA_W'(cfg_rsp.resp), '0);
  endtask

  // One LFSR step per bit taken
  task automatic next_rand(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      rnd_q = i_mem.lfsr_step(rnd_q);
      bits  = {bits[30:0], rnd_q[0]};
    end
  endtask

  // NoC stall bits are drawn only while enabled
  always @(negedge clk) begin
    if (stall_en) begin
      next_rand(1, stall_bits);
      req_stall = stall_bits[0];
      next_rand(1, stall_bits);
      res_stall = stall_bits[0];
    end else begin
      req_stall = 1'b0;
      res_stall = 1'b0;
    end
  end

  // Destination word i holds source word i and the rest stays as loaded
  function automatic logic [DATA_W-1:0] expected_word(input int a);
    logic [DATA_W-1:0] v;
    v = init_img[a];
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      if (xfer_on[e] && (a >= dst_word[e]) && (a < dst_word[e] + n_words[e])) begin
        v = init_img[src_word[e] + a - dst_word[e]];
      end
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] reg_addr(input int e, input logic [3:0] r);
    return DATA_W'(e * 16) + DATA_W'(r);
  endfunction

  task automatic preload_memory();
    logic [31:0] v;
    for (int a = 0; a < MEM_WORDS; a++) begin
      next_rand(32, v);
      i_mem.mem[a] = v;
      init_img[a]  = v;
    end
  endtask

  task automatic check_memory();
    for (int a = 0; a < MEM_WORDS; a++) begin
      check_word($sformatf("mem[%0d]", a), i_mem.mem[a], expected_word(a));
    end
  endtask

  //////////////////////////////
  // Config bus calls start and end on a falling edge
  task automatic drive_addr_phase(input logic [DATA_W-1:0] addr, input logic write);
    cfg_req.sel   = 1'b1;
    cfg_req.addr  = addr;
    cfg_req.write = write;
    cfg_req.trans = HT_NONSEQ;
  endtask

  task automatic release_bus();
    cfg_req.sel   = 1'b0;
    cfg_req.write = 1'b0;
    cfg_req.trans = HT_IDLE;
  endtask

  task automatic cfg_write(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
    drive_addr_phase(addr, 1'b1);
    @(negedge clk);
    release_bus();
    cfg_req.wdata = data;
    check_cfg_rsp();
    @(negedge clk);
  endtask

  task automatic cfg_read(input logic [DATA_W-1:0] addr, output logic [DATA_W-1:0] data);
    drive_addr_phase(addr, 1'b0);
    @(negedge clk);
    release_bus();
    check_cfg_rsp();
    data = cfg_rsp.rdata;
    @(negedge clk);
  endtask

  // The CTRL read overlaps the start's data phase before the initiator takes the entry
  task automatic start_and_read(input int e, output logic [DATA_W-1:0] ctrl);
    drive_addr_phase(reg_addr(e, REG_CTRL), 1'b1);
    @(negedge clk);
    cfg_req.wdata = DATA_W'(1);
    check_cfg_rsp();
    drive_addr_phase(reg_addr(e, REG_CTRL), 1'b0);
    @(negedge clk);
    release_bus();
    check_cfg_rsp();
    ctrl = cfg_rsp.rdata;
    @(negedge clk);
  endtask

  task automatic wait_irq(input entry_mask_t exp);
    int n;
    n = 0;
    while (irq !== exp) begin
      if (n >= TIMEOUT) begin
        $display("irq did not reach %h within %0d cycles", exp, TIMEOUT);
        abort_run();
      end
      @(negedge clk);
      n++;
    end
  endtask

  //////////////////////////////
  // Request packet monitor
  always @(posedge clk) begin
    if (rst) begin
      pkt_pos = 0;
    end else if (req_out_valid && req_out_ready) begin
      hdr_seen      = noc_header_t'(req_flit.payload);
      flit_exp.last = 1'b0;
      if (pkt_pos == 0) begin
        pkt_idx = hdr_seen.index;
        if (!xfer_on[pkt_idx]) begin
          $display("request header names entry %0d, which was never started", pkt_idx);
          abort_run();
        end
        hdr_exp          = '0;
        hdr_exp.kind     = KIND_REQ;
        hdr_exp.index    = pkt_idx;
        hdr_exp.len      = LEN_W'(n_words[pkt_idx] - 1);
        flit_exp.payload = hdr_exp;
        check_flit("request header", req_flit, flit_exp);
        hdr_count++;
      end else if (pkt_pos == 1) begin
        flit_exp.payload = DATA_W'(dst_word[pkt_idx] * 4);
        check_flit("request address", req_flit, flit_exp);
      end else begin
        flit_exp.payload = init_img[src_word[pkt_idx] + pkt_pos - 2];
        flit_exp.last    = (pkt_pos - 2 == n_words[pkt_idx] - 1);
        check_flit("request data", req_flit, flit_exp);
      end
      pkt_pos = req_flit.last ? 0 : pkt_pos + 1;
    end
  end

  // Each acknowledge answers the request packet seen last
  always @(posedge clk) begin
    if (!rst && res_out_valid && res_out_ready) begin
      ack_seen = noc_header_t'(res_flit.payload);
      check_word("ack kind", DATA_W'(ack_seen.kind), DATA_W'(KIND_ACK));
      check_word("ack index", DATA_W'(ack_seen.index), DATA_W'(pkt_idx));
      check_word("ack last", DATA_W'(res_flit.last), DATA_W'(1));
    end
  end

  //////////////////////////////
  // Main sequence
  initial begin
    logic [DATA_W-1:0] rd;
    clk       = 1'b0;
    rst       = 1'b1;
    cfg_req   = '0;
    req_stall = 1'b0;
    res_stall = 1'b0;
    stall_en  = 1'b0;
    wait_en   = 1'b0;
    rnd_q     = SEED;
    n_words   = '{5, 16, 1, 7};
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      src_word[e] = e * 16;
      dst_word[e] = 128 + e * 16;
      xfer_on[e]  = 1'b0;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;

    // Idle outputs after reset
    check_irq(irq, '0);
    check_word("noc_out_req_valid", DATA_W'(req_out_valid), '0);
    check_word("noc_out_res_valid", DATA_W'(res_out_valid), '0);
    check_word("mem_req.sel", DATA_W'(mem_req.sel), '0);
    check_word("mem_req.trans", DATA_W'(mem_req.trans), DATA_W'(HT_IDLE));

    // Field write and readback
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      cfg_write(reg_addr(e, REG_LOCAL), DATA_W'(src_word[e] * 4));
      cfg_write(reg_addr(e, REG_REMOTE), DATA_W'(dst_word[e] * 4));
      cfg_write(reg_addr(e, REG_LEN), DATA_W'(n_words[e] - 1));
    end
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      cfg_read(reg_addr(e, REG_LOCAL), rd);
      check_word($sformatf("entry %0d local", e), rd, DATA_W'(src_word[e] * 4));
      cfg_read(reg_addr(e, REG_REMOTE), rd);
      check_word($sformatf("entry %0d remote", e), rd, DATA_W'(dst_word[e] * 4));
      cfg_read(reg_addr(e, REG_LEN), rd);
      check_word($sformatf("entry %0d len", e), rd, DATA_W'(n_words[e] - 1));
    end

    // Single 5-word transfer on entry 0
    preload_memory();
    xfer_on[0] = 1'b1;
    start_and_read(0, rd);
    check_word("entry 0 ctrl", rd, DATA_W'(1));
    wait_irq(4'b0001);
    check_memory();
    check_word("request headers", DATA_W'(hdr_count), DATA_W'(1));

    // All four entries
    preload_memory();
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      xfer_on[e] = 1'b1;
    end
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      cfg_write(reg_addr(e, REG_CTRL), DATA_W'(1));
    end
    wait_irq(4'b1111);
    check_memory();
    check_word("request headers", DATA_W'(hdr_count), DATA_W'(5));

    // Same again with memory waits and NoC stalls
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      cfg_write(reg_addr(e, REG_CTRL), DATA_W'(2));
    end
    wait_irq(4'b0000);
    preload_memory();
    wait_en  = 1'b1;
    stall_en = 1'b1;
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      cfg_write(reg_addr(e, REG_CTRL), DATA_W'(1));
    end
    wait_irq(4'b1111);
    stall_en = 1'b0;
    wait_en  = 1'b0;
    check_memory();
    check_word("request headers", DATA_W'(hdr_count), DATA_W'(9));

    // Clearing done of entry 2 only
    cfg_write(reg_addr(2, REG_CTRL), DATA_W'(2));
    wait_irq(4'b1011);
    @(negedge clk);
    check_irq(irq, 4'b1011);
    cfg_read(reg_addr(1, REG_CTRL), rd);
    check_word("entry 1 ctrl", rd, DATA_W'(2));
    cfg_read(reg_addr(2, REG_CTRL), rd);
    check_word("entry 2 ctrl", rd, DATA_W'(0));

    $display("Test OK");
    $finish;
  end

endmodule

//--- vlog.f
design/dma_pkg.sv
design/dma_cfg_slave.sv
design/dma_transfer_table.sv
design/dma_initiator.sv
design/dma_target.sv
design/dma_bus_arbiter.sv
design/dma_top.sv
testbench/dma_tb_mem.sv
testbench/dma_tb.sv

//--- Bender.yml
package:
  name: noc_dma

sources:
  - design/dma_pkg.sv
  - design/dma_cfg_slave.sv
  - design/dma_transfer_table.sv
  - design/dma_initiator.sv
  - design/dma_target.sv
  - design/dma_bus_arbiter.sv
  - design/dma_top.sv
  - target: test
    files:
      - testbench/dma_tb_mem.sv
      - testbench/dma_tb.sv
